/* filelist.f */
+incdir+design
design/pixgen_pkg.sv
design/axil_regs.sv
design/conv_capture.sv
design/feature_tiler.sv
design/stream_packer.sv
design/pixel_generator.sv
sim/pixgen_checker.sv
sim/tb_pixel_generator.sv

/* Bender.yml */
package:
  name: pixel_generator

sources:
  - include_dirs:
      - design
    files:
      - design/pixgen_pkg.sv
      - design/axil_regs.sv
      - design/conv_capture.sv
      - design/feature_tiler.sv
      - design/stream_packer.sv
      - design/pixel_generator.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/pixgen_checker.sv
      - sim/tb_pixel_generator.sv

/* sim/tb_pixel_generator.sv */
// Clock, reset, image memory model, AXI-Lite tasks, reference convolution and stream compare
`timescale 1ns/100ps
`include "pixgen_defs.svh"

module tb_pixel_generator;
    localparam int D   = `PIXGEN_DISP_SIZE;
    localparam int N   = `PIXGEN_IMG_SIZE;
    localparam int TMO = 5000;           // Iterations per wait loop
    localparam logic [31:0] SEED = 32'h853a5d33;

    logic                       s_axi_lite_aclk = 1'b0;
    logic                       axi_resetn;
    logic [`PIXGEN_AXIL_AW-1:0] s_axi_lite_araddr, s_axi_lite_awaddr;
    logic                       s_axi_lite_arvalid, s_axi_lite_awvalid, s_axi_lite_wvalid;
    logic                       s_axi_lite_arready, s_axi_lite_awready, s_axi_lite_wready;
    logic                       s_axi_lite_bready, s_axi_lite_rready;
    logic                       s_axi_lite_bvalid, s_axi_lite_rvalid;
    logic [1:0]                 s_axi_lite_bresp, s_axi_lite_rresp;
    logic [31:0]                s_axi_lite_wdata, s_axi_lite_rdata;
    logic [5:0]                 img_addr, img_addr_q;
    logic [7:0]                 img_rdata;
    logic [31:0]                out_stream_tdata;
    logic [3:0]                 out_stream_tkeep;
    logic                       out_stream_tlast, out_stream_tvalid, out_stream_tready;
    logic [0:0]                 out_stream_tuser;

    logic [7:0]  img [N * N];            // Image memory model
    logic [31:0] rnd = SEED, bp_rnd = SEED;
    logic [7:0]  exp_gray;
    int          coef [9];
    int          shift;
    int          beat_idx  = 0;          // Position inside current frame
    int          frames_rx = 0;
    bit          bp_on     = 1'b0;       // Random tready when set

    pixel_generator dut (.*);

    always #10 s_axi_lite_aclk = ~s_axi_lite_aclk;

    // One cycle read latency, data driven mid-cycle
    always @(posedge s_axi_lite_aclk) img_addr_q <= img_addr;
    always @(negedge s_axi_lite_aclk) img_rdata <= img[img_addr_q];

    // ========================================
    // Helpers and reference model
    // ========================================
    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int feat_sum(input int fr, input int fc);
        int s = 0;
        for (int k = 0; k < 9; k++) begin
            s += coef[k] * int'(img[(fr + k / 3) * N + fc + k % 3]);  // Row-major taps
        end
        return s;
    endfunction

    // Expected gray at display (x, y), 2x2 upscale of the 6x6 feature map
    function automatic logic [7:0] conv_ref(input int x, input int y);
        int s;
        s = feat_sum(y / 2, x / 2) >>> shift;
        return (s < 0) ? 8'd0 : (s > 255) ? 8'd255 : 8'(s);
    endfunction

    function automatic bit clamps_both();
        bit lo = 1'b0;
        bit hi = 1'b0;
        int s;
        for (int p = 0; p < `PIXGEN_FEAT_SIZE * `PIXGEN_FEAT_SIZE; p++) begin
            s  = feat_sum(p / `PIXGEN_FEAT_SIZE, p % `PIXGEN_FEAT_SIZE) >>> shift;
            lo |= (s < 0);
            hi |= (s > 255);
        end
        return lo && hi;
    endfunction

    task automatic stop_fail();
        $display("TB FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic abort_run(input string what);
        $display("Error at %0t: %s", $time, what);
        stop_fail();
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            stop_fail();
        end
    endtask

    // ========================================
    // AXI-Lite master tasks
    // ========================================
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        logic aw_hs, w_hs;
        int   n = 0;
        @(negedge s_axi_lite_aclk);
        s_axi_lite_awaddr  = addr;
        s_axi_lite_awvalid = 1'b1;
        s_axi_lite_wdata   = data;
        s_axi_lite_wvalid  = 1'b1;
        while (s_axi_lite_awvalid || s_axi_lite_wvalid) begin
            aw_hs = s_axi_lite_awready;  // Ready stable mid-cycle
            w_hs  = s_axi_lite_wready;
            @(negedge s_axi_lite_aclk);
            if (aw_hs) s_axi_lite_awvalid = 1'b0;
            if (w_hs) s_axi_lite_wvalid = 1'b0;
            if (++n > TMO) abort_run("timeout on AXI-Lite write address or data");
        end
        n = 0;
        while (!s_axi_lite_bvalid) begin
            @(negedge s_axi_lite_aclk);
            if (++n > TMO) abort_run("timeout waiting for bvalid");
        end
        check(s_axi_lite_bresp, pixgen_pkg::resp_okay, "bresp");
        @(negedge s_axi_lite_aclk);  // bready held high
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        int n = 0;
        @(negedge s_axi_lite_aclk);
        s_axi_lite_araddr  = addr;
        s_axi_lite_arvalid = 1'b1;
        while (!s_axi_lite_arready) begin
            @(negedge s_axi_lite_aclk);
            if (++n > TMO) abort_run("timeout waiting for arready");
        end
        @(negedge s_axi_lite_aclk);
        s_axi_lite_arvalid = 1'b0;
        n = 0;
        while (!s_axi_lite_rvalid) begin
            @(negedge s_axi_lite_aclk);
            if (++n > TMO) abort_run("timeout waiting for rvalid");
        end
        data = s_axi_lite_rdata;
        check(s_axi_lite_rresp, pixgen_pkg::resp_okay, "rresp");
        @(negedge s_axi_lite_aclk);
    endtask

    task automatic load_kernel(input int sh, input bit need_clamp);
        logic [31:0] packed_coef;
        int          tries = 0;
        shift = sh;
        do begin
            for (int k = 0; k < 9; k++) begin
                rnd     = lcg(rnd);
                coef[k] = $signed(rnd[19:16]);  // -8..7
            end
            if (++tries > 100) abort_run("no kernel found that clamps at both ends");
        end while (need_clamp && !clamps_both());
        for (int k = 0; k < 8; k++) begin
            packed_coef[4*k +: 4] = coef[k][3:0];
        end
        axil_write(8'h04, packed_coef);
        axil_write(8'h08, {28'd0, coef[8][3:0]});
    endtask

    task automatic run_capture();
        logic [31:0] rd;
        int          n = 0;
        axil_write(8'h00, {20'd0, shift[3:0], 8'h01});
        axil_read(8'h0C, rd);
        check(rd, 32'h2, "status after start, busy set and done clear");
        axil_read(8'h00, rd);
        check(rd, {20'd0, shift[3:0], 8'h00}, "control readback with start bit zero");
        do begin
            axil_read(8'h0C, rd);
            if (++n > TMO) abort_run("timeout waiting for capture done");
        end while (!rd[0]);
        check(rd, 32'h1, "status after capture, done set and busy clear");
    endtask

    task automatic wait_beats(input int total);
        int n = 0;
        while (frames_rx * D * D + beat_idx < total) begin
            @(posedge s_axi_lite_aclk);  // Counters move on negedge
            if (++n > TMO) abort_run("timeout waiting for stream beats");
        end
    endtask

    // ========================================
    // Stream compare and tready pattern
    // ========================================
    always @(negedge s_axi_lite_aclk) begin
        bp_rnd = lcg(bp_rnd);
        out_stream_tready = !bp_on || bp_rnd[27];  // Beat transfers at the next rising edge
        if (axi_resetn && out_stream_tvalid && out_stream_tready) begin
            exp_gray = conv_ref(beat_idx % D, beat_idx / D);
            check(out_stream_tdata, {8'h00, exp_gray, exp_gray, exp_gray}, "tdata");
            check(out_stream_tkeep, 4'hF, "tkeep");
            check(out_stream_tuser, beat_idx == 0, "tuser");
            check(out_stream_tlast, beat_idx % D == D - 1, "tlast");
            beat_idx = (beat_idx + 1) % (D * D);
            if (beat_idx == 0) frames_rx++;
        end
    end

    // Bound assertion failures end the run
    always @(negedge s_axi_lite_aclk) begin
        if (dut.u_packer.u_stream_chk.fail_count + dut.u_tiler.u_credit_chk.fail_count != 0) begin
            abort_run("concurrent assertion failed in the bound checker");
        end
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] scratch [5:7];
        axi_resetn         = 1'b0;
        s_axi_lite_araddr  = '0;
        s_axi_lite_arvalid = 1'b0;
        s_axi_lite_awaddr  = '0;
        s_axi_lite_awvalid = 1'b0;
        s_axi_lite_wdata   = '0;
        s_axi_lite_wvalid  = 1'b0;
        s_axi_lite_bready  = 1'b1;
        s_axi_lite_rready  = 1'b1;
        img_rdata          = '0;
        out_stream_tready  = 1'b1;
        repeat (5) @(negedge s_axi_lite_aclk);
        axi_resetn = 1'b1;
        for (int i = 0; i < N * N; i++) begin
            rnd    = lcg(rnd);
            img[i] = rnd[23:16];
        end

        // Scratch registers
        for (int r = 5; r < 8; r++) begin
            rnd        = lcg(rnd);
            scratch[r] = rnd;
            axil_write(8'(4 * r), rnd);
        end
        for (int r = 5; r < 8; r++) begin
            axil_read(8'(4 * r), rd);
            check(rd, scratch[r], "scratch register readback");
        end

        // First run, shifted kernel, then two frames under back-pressure
        rnd = lcg(rnd);
        load_kernel(2 + rnd[9:8], 1'b0);
        run_capture();
        axil_write(8'h00, {20'd0, shift[3:0], 8'h02});
        wait_beats(D * D);
        bp_on = 1'b1;
        wait_beats(3 * D * D + 1);
        axil_write(8'h00, {20'd0, shift[3:0], 8'h00});  // Frame 4 in flight completes
        wait_beats(4 * D * D);
        axil_read(8'h10, rd);
        check(rd, 32'd4, "frame counter");

        // Second run, shift 0 with clamping at both ends
        load_kernel(0, 1'b1);
        run_capture();
        axil_write(8'h00, 32'h2);
        wait_beats(5 * D * D);

        if (dut.u_packer.u_stream_chk.fail_count + dut.u_tiler.u_credit_chk.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run("concurrent assertion failures reported by the checker");
        end
    end

endmodule

/* sim/pixgen_checker.sv */
// Concurrent assertions on stall stability, credit level and valid during reset, plus binds
`timescale 1ns/100ps
`include "pixgen_defs.svh"

module pixgen_checker (
    input logic        clk,
    input logic        rstn,
    input logic        vld,    // Transfer or scan in progress
    input logic        rdy,
    input logic [33:0] data,   // Payload that must hold while stalled
    input logic [7:0]  level,  // Credit count or FIFO fill
    input logic        quiet   // Valid output cleared by reset
);
    int unsigned fail_count = 0;  // Read by the testbench

    // Stalled transfer keeps its payload
    stall_stable: assert property (@(posedge clk) disable iff (!rstn)
        vld && !rdy |=> vld && $stable(data))
    else begin
        $error("beat dropped or changed while stalled");
        fail_count++;
    end

    level_bound: assert property (@(posedge clk) disable iff (!rstn)
        level <= `PIXGEN_CREDITS)
    else begin
        $error("credit level above limit");
        fail_count++;
    end

    // Synchronous reset clears valid one edge later
    reset_quiet: assert property (@(posedge clk) !rstn |=> !quiet)
    else begin
        $error("valid high during reset");
        fail_count++;
    end

endmodule

// ========================================
// Attach to the credit link and the stream
// ========================================
bind stream_packer pixgen_checker u_stream_chk (
    .clk   (s_axi_lite_aclk),
    .rstn  (axi_resetn),
    .vld   (out_stream_tvalid),
    .rdy   (out_stream_tready),
    .data  ({out_stream_tuser, out_stream_tlast, out_stream_tdata}),
    .level (8'(count)),          // FIFO fill never exceeds depth
    .quiet (out_stream_tvalid)
);

bind feature_tiler pixgen_checker u_credit_chk (
    .clk   (s_axi_lite_aclk),
    .rstn  (axi_resetn),
    .vld   (active),
    .rdy   (credit_cnt != '0),   // Out of credits stalls the scan
    .data  (34'({x, y})),        // Scan position holds, no beat skipped
    .level (8'(credit_cnt)),
    .quiet (beat_valid)
);

/* design/pixel_generator.sv */
// Top level: AXI-Lite registers, convolution capture, feature tiler and stream packer
`timescale 1ns/100ps
`include "pixgen_defs.svh"

module pixel_generator (
    input  logic                       s_axi_lite_aclk,
    input  logic                       axi_resetn,
    input  logic [`PIXGEN_AXIL_AW-1:0] s_axi_lite_araddr,
    output logic                       s_axi_lite_arready,
    input  logic                       s_axi_lite_arvalid,
    input  logic [`PIXGEN_AXIL_AW-1:0] s_axi_lite_awaddr,
    output logic                       s_axi_lite_awready,
    input  logic                       s_axi_lite_awvalid,
    input  logic                       s_axi_lite_bready,
    output logic [1:0]                 s_axi_lite_bresp,
    output logic                       s_axi_lite_bvalid,
    output logic [31:0]                s_axi_lite_rdata,
    input  logic                       s_axi_lite_rready,
    output logic [1:0]                 s_axi_lite_rresp,
    output logic                       s_axi_lite_rvalid,
    input  logic [31:0]                s_axi_lite_wdata,
    output logic                       s_axi_lite_wready,
    input  logic                       s_axi_lite_wvalid,
    output logic [5:0]                 img_addr,
    input  logic [7:0]                 img_rdata,
    output logic [31:0]                out_stream_tdata,
    output logic [3:0]                 out_stream_tkeep,
    output logic                       out_stream_tlast,
    output logic [0:0]                 out_stream_tuser,
    output logic                       out_stream_tvalid,
    input  logic                       out_stream_tready
);
    logic                  start, frame_en, busy, done;
    logic                  beat_valid, credit_return;
    logic [31:0]           frame_count;
    pixgen_pkg::conv_cfg_t cfg;
    pixgen_pkg::feat_wr_t  feat_wr;
    pixgen_pkg::pix_beat_t beat;

    // Control plane
    axil_regs u_regs (
        .s_axi_lite_aclk, .axi_resetn,
        .s_axi_lite_araddr, .s_axi_lite_arready, .s_axi_lite_arvalid,
        .s_axi_lite_awaddr, .s_axi_lite_awready, .s_axi_lite_awvalid,
        .s_axi_lite_bready, .s_axi_lite_bresp, .s_axi_lite_bvalid,
        .s_axi_lite_rdata, .s_axi_lite_rready, .s_axi_lite_rresp, .s_axi_lite_rvalid,
        .s_axi_lite_wdata, .s_axi_lite_wready, .s_axi_lite_wvalid,
        .start, .frame_en, .cfg, .busy, .done, .frame_count
    );

    // Image port to feature buffer
    conv_capture u_capture (
        .s_axi_lite_aclk, .axi_resetn, .start, .cfg,
        .img_addr, .img_rdata, .feat_wr, .busy, .done
    );

    // Feature buffer to credit link
    feature_tiler u_tiler (
        .s_axi_lite_aclk, .axi_resetn, .start, .frame_en, .feat_wr,
        .cap_done (done),
        .beat, .beat_valid, .credit_return, .frame_count
    );

    stream_packer u_packer (
        .s_axi_lite_aclk, .axi_resetn, .beat, .beat_valid, .credit_return,
        .out_stream_tdata, .out_stream_tkeep, .out_stream_tlast,
        .out_stream_tuser, .out_stream_tvalid, .out_stream_tready
    );

endmodule

/* design/stream_packer.sv */
// Credit FIFO of display beats, gray-to-RGB AXI-Stream formatting, credit return per transfer
`timescale 1ns/100ps
`include "pixgen_defs.svh"

module stream_packer (
    input  logic                  s_axi_lite_aclk,
    input  logic                  axi_resetn,
    input  pixgen_pkg::pix_beat_t beat,
    input  logic                  beat_valid,
    output logic                  credit_return,
    output logic [31:0]           out_stream_tdata,
    output logic [3:0]            out_stream_tkeep,
    output logic                  out_stream_tlast,
    output logic [0:0]            out_stream_tuser,
    output logic                  out_stream_tvalid,
    input  logic                  out_stream_tready
);
    localparam int DEPTH = `PIXGEN_CREDITS;
    localparam int PW    = $clog2(DEPTH);

    pixgen_pkg::pix_beat_t fifo [DEPTH];
    pixgen_pkg::pix_beat_t head;
    logic [PW-1:0]         wr_ptr, rd_ptr;  // Wrap naturally, depth is a power of two
    logic [PW:0]           count;
    logic                  pop;

    assign head = fifo[rd_ptr];
    assign pop  = out_stream_tvalid && out_stream_tready;

    // Tiler never pushes without a credit, so no full check
    always_ff @(posedge s_axi_lite_aclk) begin
        if (beat_valid) fifo[wr_ptr] <= beat;
    end

    always_ff @(posedge s_axi_lite_aclk) begin
        if (!axi_resetn) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            wr_ptr        <= wr_ptr + PW'(beat_valid);
            rd_ptr        <= rd_ptr + PW'(pop);
            count         <= count + beat_valid - pop;
            credit_return <= pop;  // One slot freed per transfer
        end
    end

    // ========================================
    // AXI-Stream view of FIFO head
    // ========================================
    assign out_stream_tvalid = (count != '0);
    assign out_stream_tdata  = {8'h00, head.gray, head.gray, head.gray};  // R, G, B equal
    assign out_stream_tkeep  = 4'hF;
    assign out_stream_tlast  = head.eol;
    assign out_stream_tuser  = head.sof;

endmodule

/* design/feature_tiler.sv */
// Feature buffer, feature valid flag, 12x12 display scan with 2x upscale, credits, frame count
`timescale 1ns/100ps
`include "pixgen_defs.svh"

module feature_tiler (
    input  logic                  s_axi_lite_aclk,
    input  logic                  axi_resetn,
    input  logic                  start,
    input  logic                  frame_en,
    input  pixgen_pkg::feat_wr_t  feat_wr,
    input  logic                  cap_done,
    output pixgen_pkg::pix_beat_t beat,
    output logic                  beat_valid,
    input  logic                  credit_return,
    output logic [31:0]           frame_count
);
    localparam int CW = $clog2(`PIXGEN_CREDITS + 1);

    logic [7:0]    fbuf [`PIXGEN_FEAT_SIZE * `PIXGEN_FEAT_SIZE];
    logic          feat_valid, active, spend;
    logic [3:0]    x, y;        // Display coordinates
    logic [CW-1:0] credit_cnt;  // Free slots in packer FIFO
    logic [5:0]    rd_addr;

    assign rd_addr = 6'(y[3:1] * `PIXGEN_FEAT_SIZE + x[3:1]);  // 2x2 replicate
    assign spend   = active && (credit_cnt != '0);

    always_ff @(posedge s_axi_lite_aclk) begin
        if (feat_wr.valid) fbuf[feat_wr.addr] <= feat_wr.data;
    end

    // Beat payload, valid flag below
    always_ff @(posedge s_axi_lite_aclk) begin
        if (spend) begin
            beat <= '{gray: fbuf[rd_addr],
                      sof:  (x == 4'd0) && (y == 4'd0),
                      eol:  x == 4'(`PIXGEN_DISP_SIZE - 1)};
        end
    end

    // ========================================
    // Scan, credits and frame count
    // ========================================
    always_ff @(posedge s_axi_lite_aclk) begin
        if (!axi_resetn) begin
            feat_valid  <= 1'b0;
            active      <= 1'b0;
            x           <= '0;
            y           <= '0;
            credit_cnt  <= CW'(`PIXGEN_CREDITS);
            beat_valid  <= 1'b0;
            frame_count <= '0;
        end else begin
            credit_cnt <= credit_cnt - spend + credit_return;
            beat_valid <= spend;
            if (start) begin
                feat_valid <= 1'b0;  // Old features stale once capture restarts
            end else if (cap_done) begin
                feat_valid <= 1'b1;
            end
            if (!active) begin
                active <= feat_valid && frame_en;
            end else if (spend) begin
                if (x == 4'd0 && y == 4'd0) frame_count <= frame_count + 32'd1;
                if (x == 4'(`PIXGEN_DISP_SIZE - 1)) begin
                    x <= '0;
                    if (y == 4'(`PIXGEN_DISP_SIZE - 1)) begin
                        y      <= '0;
                        active <= 1'b0;  // Frame done, rearm checks frame_en
                    end else begin
                        y <= y + 4'd1;
                    end
                end else begin
                    x <= x + 4'd1;
                end
            end
        end
    end

endmodule

/* design/conv_capture.sv */
// Image read sequencer, 3x3 multiply-accumulate, shift and clamp, feature buffer writes
`timescale 1ns/100ps
`include "pixgen_defs.svh"

module conv_capture (
    input  logic                  s_axi_lite_aclk,
    input  logic                  axi_resetn,
    input  logic                  start,
    input  pixgen_pkg::conv_cfg_t cfg,
    output logic [5:0]            img_addr,
    input  logic [7:0]            img_rdata,
    output pixgen_pkg::feat_wr_t  feat_wr,
    output logic                  busy,
    output logic                  done
);
    pixgen_pkg::cap_state_e state;
    logic [2:0]             row, col;  // Output position
    logic [1:0]             kr, kc;    // Kernel tap
    logic [3:0]             tap;
    logic signed [15:0]     sum, prod, shifted;
    logic [7:0]             clamped;

    assign tap      = 4'(kr * `PIXGEN_KSIZE + kc);
    assign img_addr = 6'((row + kr) * `PIXGEN_IMG_SIZE + col + kc);
    assign prod     = $signed(cfg.coef[tap]) * $signed({1'b0, img_rdata});  // Pixel is unsigned
    assign shifted  = sum >>> cfg.shift;

    // Clamp to 0..255
    always_comb begin
        if (shifted < 0) begin
            clamped = 8'd0;
        end else if (shifted > 16'sd255) begin
            clamped = 8'd255;
        end else begin
            clamped = shifted[7:0];
        end
    end

    // ========================================
    // Capture FSM, two cycles per tap
    // ========================================
    always_ff @(posedge s_axi_lite_aclk) begin
        if (!axi_resetn) begin
            state         <= pixgen_pkg::cap_idle;
            feat_wr.valid <= 1'b0;
            row           <= '0;
            col           <= '0;
            kr            <= '0;
            kc            <= '0;
        end else begin
            feat_wr.valid <= 1'b0;
            case (state)
                pixgen_pkg::cap_idle, pixgen_pkg::cap_done: if (start) begin
                    row   <= '0;
                    col   <= '0;
                    kr    <= '0;
                    kc    <= '0;
                    sum   <= '0;
                    state <= pixgen_pkg::cap_read;
                end
                pixgen_pkg::cap_read: state <= pixgen_pkg::cap_acc;  // Data lands next cycle
                pixgen_pkg::cap_acc: begin
                    sum   <= sum + prod;
                    state <= pixgen_pkg::cap_read;
                    if (kc == 2'(`PIXGEN_KSIZE - 1)) begin
                        kc <= '0;
                        if (kr == 2'(`PIXGEN_KSIZE - 1)) begin
                            kr    <= '0;
                            state <= pixgen_pkg::cap_write;  // All nine taps summed
                        end else begin
                            kr <= kr + 2'd1;
                        end
                    end else begin
                        kc <= kc + 2'd1;
                    end
                end
                pixgen_pkg::cap_write: begin
                    feat_wr <= '{valid: 1'b1,
                                 addr:  6'(row * `PIXGEN_FEAT_SIZE + col),
                                 data:  clamped};
                    sum     <= '0;
                    state   <= pixgen_pkg::cap_read;
                    if (col == 3'(`PIXGEN_FEAT_SIZE - 1)) begin
                        col <= '0;
                        if (row == 3'(`PIXGEN_FEAT_SIZE - 1)) begin
                            state <= pixgen_pkg::cap_done;  // Last of 36 positions
                        end else begin
                            row <= row + 3'd1;
                        end
                    end else begin
                        col <= col + 3'd1;
                    end
                end
                default: state <= pixgen_pkg::cap_idle;
            endcase
        end
    end

    assign busy = (state == pixgen_pkg::cap_read) || (state == pixgen_pkg::cap_acc) ||
                  (state == pixgen_pkg::cap_write);
    assign done = (state == pixgen_pkg::cap_done);  // Held until next start

endmodule

/* design/axil_regs.sv */
// AXI-Lite slave with register file, start pulse, kernel config, status and frame count reads
`timescale 1ns/100ps
`include "pixgen_defs.svh"

module axil_regs (
    input  logic                       s_axi_lite_aclk,
    input  logic                       axi_resetn,
    input  logic [`PIXGEN_AXIL_AW-1:0] s_axi_lite_araddr,
    output logic                       s_axi_lite_arready,
    input  logic                       s_axi_lite_arvalid,
    input  logic [`PIXGEN_AXIL_AW-1:0] s_axi_lite_awaddr,
    output logic                       s_axi_lite_awready,
    input  logic                       s_axi_lite_awvalid,
    input  logic                       s_axi_lite_bready,
    output logic [1:0]                 s_axi_lite_bresp,
    output logic                       s_axi_lite_bvalid,
    output logic [31:0]                s_axi_lite_rdata,
    input  logic                       s_axi_lite_rready,
    output logic [1:0]                 s_axi_lite_rresp,
    output logic                       s_axi_lite_rvalid,
    input  logic [31:0]                s_axi_lite_wdata,
    output logic                       s_axi_lite_wready,
    input  logic                       s_axi_lite_wvalid,
    output logic                       start,
    output logic                       frame_en,
    output pixgen_pkg::conv_cfg_t      cfg,
    input  logic                       busy,
    input  logic                       done,
    input  logic [31:0]                frame_count
);
    localparam int IW = $clog2(`PIXGEN_REG_COUNT);

    logic [31:0]              regs [`PIXGEN_REG_COUNT];
    pixgen_pkg::axil_wstate_e wstate;
    pixgen_pkg::axil_rstate_e rstate;
    logic [IW-1:0]            waddr, raddr;  // Word index from addr[4:2]
    logic [31:0]              wdata_q, rmux;

    // ========================================
    // Write channel
    // ========================================
    always_ff @(posedge s_axi_lite_aclk) begin
        if (!axi_resetn) begin
            wstate <= pixgen_pkg::await_addr_and_data;
            start  <= 1'b0;
            for (int i = 0; i < `PIXGEN_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            start <= 1'b0;  // Single-cycle pulse
            case (wstate)
                pixgen_pkg::await_addr_and_data: begin
                    if (s_axi_lite_awvalid) waddr <= s_axi_lite_awaddr[2 +: IW];
                    if (s_axi_lite_wvalid) wdata_q <= s_axi_lite_wdata;
                    case ({s_axi_lite_awvalid, s_axi_lite_wvalid})
                        2'b11:   wstate <= pixgen_pkg::do_write;
                        2'b10:   wstate <= pixgen_pkg::await_data;
                        2'b01:   wstate <= pixgen_pkg::await_addr;
                        default: wstate <= pixgen_pkg::await_addr_and_data;
                    endcase
                end
                pixgen_pkg::await_data: if (s_axi_lite_wvalid) begin
                    wdata_q <= s_axi_lite_wdata;
                    wstate  <= pixgen_pkg::do_write;
                end
                pixgen_pkg::await_addr: if (s_axi_lite_awvalid) begin
                    waddr  <= s_axi_lite_awaddr[2 +: IW];
                    wstate <= pixgen_pkg::do_write;
                end
                pixgen_pkg::do_write: begin
                    if (waddr == '0) begin
                        regs[0] <= {wdata_q[31:1], 1'b0};  // Start bit never stored
                        start   <= wdata_q[0];
                    end else if (waddr != IW'(3) && waddr != IW'(4)) begin
                        regs[waddr] <= wdata_q;  // Status and counter are read-only
                    end
                    wstate <= pixgen_pkg::await_resp;
                end
                pixgen_pkg::await_resp:
                    if (s_axi_lite_bready) wstate <= pixgen_pkg::await_addr_and_data;
                default: wstate <= pixgen_pkg::await_addr_and_data;
            endcase
        end
    end

    assign s_axi_lite_awready = (wstate == pixgen_pkg::await_addr_and_data) ||
                                (wstate == pixgen_pkg::await_addr);
    assign s_axi_lite_wready  = (wstate == pixgen_pkg::await_addr_and_data) ||
                                (wstate == pixgen_pkg::await_data);
    assign s_axi_lite_bvalid  = (wstate == pixgen_pkg::await_resp);
    assign s_axi_lite_bresp   = pixgen_pkg::resp_okay;  // All eight indices decode

    // ========================================
    // Read channel
    // ========================================
    always_comb begin
        case (raddr)
            IW'(3):  rmux = {30'd0, busy, done};  // Live status
            IW'(4):  rmux = frame_count;
            default: rmux = regs[raddr];
        endcase
    end

    always_ff @(posedge s_axi_lite_aclk) begin
        if (!axi_resetn) begin
            rstate <= pixgen_pkg::await_raddr;
        end else begin
            case (rstate)
                pixgen_pkg::await_raddr: if (s_axi_lite_arvalid) begin
                    raddr  <= s_axi_lite_araddr[2 +: IW];
                    rstate <= pixgen_pkg::fetch;
                end
                pixgen_pkg::fetch: begin
                    s_axi_lite_rdata <= rmux;  // Sampled one cycle after AR
                    rstate           <= pixgen_pkg::await_read;
                end
                pixgen_pkg::await_read:
                    if (s_axi_lite_rready) rstate <= pixgen_pkg::await_raddr;
                default: rstate <= pixgen_pkg::await_raddr;
            endcase
        end
    end

    assign s_axi_lite_arready = (rstate == pixgen_pkg::await_raddr);
    assign s_axi_lite_rvalid  = (rstate == pixgen_pkg::await_read);
    assign s_axi_lite_rresp   = pixgen_pkg::resp_okay;

    // Kernel config straight from the register file
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            cfg.coef[k] = regs[1][4*k +: 4];
        end
        cfg.coef[8] = regs[2][3:0];
        cfg.shift   = regs[0][11:8];
    end

    assign frame_en = regs[0][1];

endmodule

/* design/pixgen_pkg.sv */
// AXI-Lite FSM state and response enums, capture state enum, kernel/write/beat structs
package pixgen_pkg;

    // AXI-Lite write channel FSM
    typedef enum logic [2:0] {
        await_addr_and_data = 3'b000,
        await_data          = 3'b001,
        await_addr          = 3'b010,
        do_write            = 3'b100,
        await_resp          = 3'b101
    } axil_wstate_e;

    // AXI-Lite read channel FSM
    typedef enum logic [1:0] {
        await_raddr = 2'b00,
        fetch       = 2'b01,
        await_read  = 2'b10
    } axil_rstate_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_e;

    typedef enum logic [2:0] {
        cap_idle, cap_read, cap_acc, cap_write, cap_done
    } cap_state_e;

    typedef logic signed [3:0] coef_t;

    typedef struct packed {
        coef_t [8:0] coef;   // Row-major, coef[0] is top left
        logic  [3:0] shift;  // Arithmetic right shift of the sum
    } conv_cfg_t;

    typedef struct packed {
        logic       valid;
        logic [5:0] addr;  // row*6 + col
        logic [7:0] data;
    } feat_wr_t;

    typedef struct packed {
        logic [7:0] gray;
        logic       sof;   // First pixel of frame
        logic       eol;   // Last pixel of line
    } pix_beat_t;

endpackage

/* design/pixgen_defs.svh */
// Image, kernel, feature and display sizes, register count, credit depth, AXI-Lite width
`ifndef PIXGEN_DEFS_SVH
`define PIXGEN_DEFS_SVH

// ========================================
// Geometry
// ========================================
`define PIXGEN_IMG_SIZE   8   // Input image width and height
`define PIXGEN_KSIZE      3   // Kernel width and height
`define PIXGEN_FEAT_SIZE  6   // IMG_SIZE - KSIZE + 1, no padding
`define PIXGEN_DISP_SIZE  12  // Each feature pixel drawn as 2x2

// ========================================
// Control and flow
// ========================================
`define PIXGEN_REG_COUNT  8   // AXI-Lite register file entries
`define PIXGEN_CREDITS    4   // Packer FIFO depth, also initial credits
`define PIXGEN_AXIL_AW    8   // AXI-Lite address width

`endif
